/* radio_ctrl_consts.svh */
// Register map and fixed values of the radio control plane
// Include in any module that decodes settings addresses or readback words
`ifndef RADIO_CTRL_CONSTS_SVH
`define RADIO_CTRL_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Settings bus bases

`define SR_MISC   0      // Misc pin control block of 9 regs
`define SR_TIME64 192    // Time high, time low, load control

// LED source after reset selects hardware for bits 4..1
`define LED_SRC_RESET 8'h1E

// Bump when the register map changes in a way software can see
`define COMPAT_NUM 32'd5

//////////////////////////////////////////////////////////////////////
// Readback word indexes

`define RB_TIME_HI 10
`define RB_TIME_LO 11
`define RB_COMPAT  12
`define RB_PPS_HI  14
`define RB_PPS_LO  15

`endif

/* radio_ctrl_pkg.sv */
// Types shared by the control plane blocks and their testbench
// Ports name them with the package scope and bodies import it
package radio_ctrl_pkg;

   //////////////////////////////////////////////////////////////////////
   // Settings bus

   // Register address on the settings bus
   typedef logic [7:0] set_addr_t;

   // One settings write word
   typedef logic [31:0] set_data_t;

   //////////////////////////////////////////////////////////////////////
   // Timing and pins

   // VITA time in sample clock ticks
   typedef logic [63:0] vita_time_t;

   // Control register or LED vector
   typedef logic [7:0] ctrl_byte_t;

   //////////////////////////////////////////////////////////////////////
   // Readback port

   // Selects one of 16 readback words
   typedef logic [3:0] rb_addr_t;

endpackage

/* setting_reg.sv */
// One register on the settings bus that loads the low bits of a matching write
// Instantiated once per address with the payload type it should hold
`timescale 1ns/10ps

module setting_reg #(
   parameter type                       payload_t = logic [7:0],
   parameter radio_ctrl_pkg::set_addr_t ADDR      = '0,
   parameter payload_t                  RESET_VAL = '0
) (
   input  logic                      dsp_clk,
   input  logic                      por_rst,     // System reset from the parent
   input  logic                      set_stb_i,
   input  radio_ctrl_pkg::set_addr_t set_addr_i,
   input  radio_ctrl_pkg::set_data_t set_data_i,
   output payload_t                  value_o
);

   import radio_ctrl_pkg::*;

   localparam int unsigned PAY_W = $bits(payload_t);

   // Payload has to fit in one bus word
   if (PAY_W > $bits(set_data_t)) begin : g_width_check
      $error("setting_reg payload is wider than the settings data word");
   end

   logic hit;

   assign hit = set_stb_i && (set_addr_i == ADDR);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         value_o <= RESET_VAL;
      end else if (hit) begin
         value_o <= payload_t'(set_data_i[PAY_W-1:0]);  // Upper data bits dropped
      end
   end

endmodule

/* boot_reset_seq.sv */
// Reset sequencer for the control plane. Holds the system reset through power-on
// and fires it once more when the bootloader reports that it is done
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module boot_reset_seq (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic                      set_stb_i,
   input  radio_ctrl_pkg::set_addr_t set_addr_i,
   input  radio_ctrl_pkg::set_data_t set_data_i,
   output logic                      sys_rst_o,
   output logic                      boot_done_o
);

   import radio_ctrl_pkg::*;

   typedef enum logic {
      ST_WAIT = 1'b0,   // Bootloader still running
      ST_DONE = 1'b1    // Main program running, terminal state
   } boot_state_t;

   boot_state_t state;
   logic        bldr_wr;

   // Bootloader done flag written with bit0 set
   assign bldr_wr = set_stb_i && (set_addr_i == set_addr_t'(`SR_MISC + 5)) && set_data_i[0];

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state     <= ST_WAIT;
         sys_rst_o <= 1'b1;
      end else begin
         case (state)
            ST_WAIT: begin
               sys_rst_o <= bldr_wr;        // One cycle of reset on the way out
               if (bldr_wr) begin
                  state <= ST_DONE;
               end
            end
            ST_DONE: begin
               sys_rst_o <= 1'b0;           // Only power-on leaves this state
            end
            default: begin
               state     <= ST_WAIT;
               sys_rst_o <= 1'b1;
            end
         endcase
      end
   end

   assign boot_done_o = (state == ST_DONE);

   // Outside power-on the reset is a single cycle pulse
   a_sys_rst_pulse: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !por_rst && sys_rst_o |=> !sys_rst_o);

endmodule

/* pin_ctrl_regs.sv */
// Misc pin control registers for the clock generator, SERDES, ADC and PHY reset,
// plus the LED mux that picks hardware or software state per LED bit
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module pin_ctrl_regs (
   input  logic                       dsp_clk,
   input  logic                       sys_rst_i,
   input  logic                       set_stb_i,
   input  radio_ctrl_pkg::set_addr_t  set_addr_i,
   input  radio_ctrl_pkg::set_data_t  set_data_i,
   input  logic                       run_tx_i,
   input  logic                       run_rx_i,
   input  logic                       clk_status_i,
   input  logic                       serdes_link_i,
   output logic                       clock_ready_o,
   output logic [1:0]                 clk_en_o,
   output logic [1:0]                 clk_sel_o,
   output logic                       ser_enable_o,
   output logic                       ser_prbsen_o,
   output logic                       ser_loopen_o,
   output logic                       ser_rx_en_o,
   output logic                       adc_oe_a_o,
   output logic                       adc_on_a_o,
   output logic                       adc_oe_b_o,
   output logic                       adc_on_b_o,
   output logic                       phy_reset_n_o,
   output radio_ctrl_pkg::ctrl_byte_t leds_o
);

   import radio_ctrl_pkg::*;

   logic [4:0] clock_outs;
   logic [3:0] serdes_outs;
   logic [3:0] adc_outs;
   logic       phy_reset;
   ctrl_byte_t led_sw;
   ctrl_byte_t led_src;
   ctrl_byte_t led_hw;

   //////////////////////////////////////////////////////////////////////
   // Register bank

   setting_reg #(.payload_t(logic [4:0]), .ADDR(set_addr_t'(`SR_MISC + 0)), .RESET_VAL('0))
      sr_clk (.dsp_clk(dsp_clk), .por_rst(sys_rst_i), .set_stb_i(set_stb_i),
              .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(clock_outs));

   setting_reg #(.payload_t(logic [3:0]), .ADDR(set_addr_t'(`SR_MISC + 1)), .RESET_VAL('0))
      sr_ser (.dsp_clk(dsp_clk), .por_rst(sys_rst_i), .set_stb_i(set_stb_i),
              .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(serdes_outs));

   setting_reg #(.payload_t(logic [3:0]), .ADDR(set_addr_t'(`SR_MISC + 2)), .RESET_VAL('0))
      sr_adc (.dsp_clk(dsp_clk), .por_rst(sys_rst_i), .set_stb_i(set_stb_i),
              .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(adc_outs));

   setting_reg #(.payload_t(ctrl_byte_t), .ADDR(set_addr_t'(`SR_MISC + 3)), .RESET_VAL('0))
      sr_led (.dsp_clk(dsp_clk), .por_rst(sys_rst_i), .set_stb_i(set_stb_i),
              .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(led_sw));

   setting_reg #(.payload_t(logic), .ADDR(set_addr_t'(`SR_MISC + 4)), .RESET_VAL(1'b0))
      sr_phy (.dsp_clk(dsp_clk), .por_rst(sys_rst_i), .set_stb_i(set_stb_i),
              .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(phy_reset));

   // 1 = hardware drives the LED, 0 = software value
   setting_reg #(.payload_t(ctrl_byte_t), .ADDR(set_addr_t'(`SR_MISC + 8)),
                 .RESET_VAL(`LED_SRC_RESET))
      sr_led_src (.dsp_clk(dsp_clk), .por_rst(sys_rst_i), .set_stb_i(set_stb_i),
                  .set_addr_i(set_addr_i), .set_data_i(set_data_i), .value_o(led_src));

   //////////////////////////////////////////////////////////////////////
   // Pin mapping

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_outs;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_outs;
   assign phy_reset_n_o = ~phy_reset;     // PHY reset pin is active low

   // Bit 0 has no hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* vita_timer.sv */
// 64-bit VITA time counter on dsp_clk. Loads at once or at the next PPS edge
// and keeps the time seen at the most recent PPS for readback
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module vita_timer (
   input  logic                       dsp_clk,
   input  logic                       sys_rst_i,
   input  logic                       set_stb_i,
   input  radio_ctrl_pkg::set_addr_t  set_addr_i,
   input  radio_ctrl_pkg::set_data_t  set_data_i,
   input  logic                       pps_i,
   output radio_ctrl_pkg::vita_time_t vita_time_o,
   output radio_ctrl_pkg::vita_time_t vita_time_pps_o,
   output logic                       pps_int_o
);

   import radio_ctrl_pkg::*;

   set_data_t  time_hi_q;     // Staged high word
   set_data_t  time_lo_q;     // Staged low word
   vita_time_t staged;
   logic       arm_q;         // Load waits for PPS
   logic       pps_meta;
   logic       pps_sync;
   logic       pps_dly;
   logic       pps_edge;
   logic       wr_hi;
   logic       wr_lo;
   logic       wr_ctrl;
   logic       load_now;

   assign wr_hi    = set_stb_i && (set_addr_i == set_addr_t'(`SR_TIME64 + 0));
   assign wr_lo    = set_stb_i && (set_addr_i == set_addr_t'(`SR_TIME64 + 1));
   assign wr_ctrl  = set_stb_i && (set_addr_i == set_addr_t'(`SR_TIME64 + 2));
   assign load_now = wr_ctrl && !set_data_i[0];
   assign staged   = {time_hi_q, time_lo_q};

   always_ff @(posedge dsp_clk) begin
      if (sys_rst_i) begin
         time_hi_q <= '0;
         time_lo_q <= '0;
      end else begin
         if (wr_hi) begin
            time_hi_q <= set_data_i;
         end
         if (wr_lo) begin
            time_lo_q <= set_data_i;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge detect

   always_ff @(posedge dsp_clk) begin
      if (sys_rst_i) begin
         pps_meta  <= 1'b0;
         pps_sync  <= 1'b0;
         pps_dly   <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_meta  <= pps_i;
         pps_sync  <= pps_meta;
         pps_dly   <= pps_sync;
         pps_int_o <= pps_edge;      // Aligned with the time capture
      end
   end

   assign pps_edge = pps_sync && !pps_dly;

   //////////////////////////////////////////////////////////////////////
   // Counter, arm flag and PPS latch

   always_ff @(posedge dsp_clk) begin
      if (sys_rst_i) begin
         arm_q <= 1'b0;
      end else if (wr_ctrl) begin
         arm_q <= set_data_i[0];
      end else if (pps_edge) begin
         arm_q <= 1'b0;              // One shot per arm
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (sys_rst_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end else begin
         if (load_now || (pps_edge && arm_q)) begin
            vita_time_o <= staged;
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end
         if (pps_edge) begin
            vita_time_pps_o <= arm_q ? staged : vita_time_o;
         end
      end
   end

   // Edge detect gives a single cycle interrupt even for a long PPS pulse
   a_pps_int_pulse: assert property (@(posedge dsp_clk) disable iff (sys_rst_i)
      pps_int_o |=> !pps_int_o);

endmodule

/* readback_mux.sv */
// Registered readback port of 16 words with time, PPS time and compatibility
// number. A strobe gets its data and acknowledge one cycle later
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module readback_mux (
   input  logic                       dsp_clk,
   input  logic                       sys_rst_i,
   input  logic                       rd_stb_i,
   input  radio_ctrl_pkg::rb_addr_t   rd_addr_i,
   input  radio_ctrl_pkg::vita_time_t vita_time_i,
   input  radio_ctrl_pkg::vita_time_t vita_time_pps_i,
   output radio_ctrl_pkg::set_data_t  rd_data_o,
   output logic                       rd_ack_o
);

   import radio_ctrl_pkg::*;

   set_data_t word_sel;

   // Unlisted words read as zero
   always_comb begin
      case (rd_addr_i)
         rb_addr_t'(`RB_TIME_HI): word_sel = vita_time_i[63:32];
         rb_addr_t'(`RB_TIME_LO): word_sel = vita_time_i[31:0];
         rb_addr_t'(`RB_COMPAT):  word_sel = `COMPAT_NUM;
         rb_addr_t'(`RB_PPS_HI):  word_sel = vita_time_pps_i[63:32];
         rb_addr_t'(`RB_PPS_LO):  word_sel = vita_time_pps_i[31:0];
         default:                 word_sel = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rd_stb_i) begin
         rd_data_o <= word_sel;
      end
   end

   // Back to back strobes get back to back acks
   always_ff @(posedge dsp_clk) begin
      if (sys_rst_i) begin
         rd_ack_o <= 1'b0;
      end else begin
         rd_ack_o <= rd_stb_i;
      end
   end

   a_ack_follows_stb: assert property (@(posedge dsp_clk) disable iff (sys_rst_i)
      rd_ack_o |-> $past(rd_stb_i));

endmodule

/* radio_ctrl_core.sv */
// Top level of the radio control plane on dsp_clk
// Settings bus in, pin controls, LEDs, VITA time and readback out
`timescale 1ns/10ps

module radio_ctrl_core (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   // Settings bus
   input  logic                       set_stb_i,
   input  radio_ctrl_pkg::set_addr_t  set_addr_i,
   input  radio_ctrl_pkg::set_data_t  set_data_i,
   // Status for the LEDs
   input  logic                       run_tx_i,
   input  logic                       run_rx_i,
   input  logic                       clk_status_i,
   input  logic                       serdes_link_i,
   input  logic                       pps_i,
   // Readback
   input  logic                       rd_stb_i,
   input  radio_ctrl_pkg::rb_addr_t   rd_addr_i,
   output radio_ctrl_pkg::set_data_t  rd_data_o,
   output logic                       rd_ack_o,
   // Pin controls
   output logic                       clock_ready_o,
   output logic [1:0]                 clk_en_o,
   output logic [1:0]                 clk_sel_o,
   output logic                       ser_enable_o,
   output logic                       ser_prbsen_o,
   output logic                       ser_loopen_o,
   output logic                       ser_rx_en_o,
   output logic                       adc_oe_a_o,
   output logic                       adc_on_a_o,
   output logic                       adc_oe_b_o,
   output logic                       adc_on_b_o,
   output logic                       phy_reset_n_o,
   output radio_ctrl_pkg::ctrl_byte_t leds_o,
   output logic                       boot_done_o,
   output logic                       pps_int_o
);

   import radio_ctrl_pkg::*;

   logic       sys_rst;          // Power-on plus the boot pulse
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   //////////////////////////////////////////////////////////////////////
   // Reset and register blocks

   boot_reset_seq u_boot (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .sys_rst_o(sys_rst), .boot_done_o(boot_done_o));

   pin_ctrl_regs u_pins (
      .dsp_clk(dsp_clk), .sys_rst_i(sys_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_tx_i(run_tx_i), .run_rx_i(run_rx_i),
      .clk_status_i(clk_status_i), .serdes_link_i(serdes_link_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   //////////////////////////////////////////////////////////////////////
   // Timing and readback

   vita_timer u_time (
      .dsp_clk(dsp_clk), .sys_rst_i(sys_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o));

   readback_mux u_rb (
      .dsp_clk(dsp_clk), .sys_rst_i(sys_rst),
      .rd_stb_i(rd_stb_i), .rd_addr_i(rd_addr_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .rd_data_o(rd_data_o), .rd_ack_o(rd_ack_o));

endmodule

/* tb_radio_ctrl_core.sv */
// Self-checking testbench for the radio control plane top level
// Concurrent assertions compare the DUT with expected values kept by the stimulus
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module tb_radio_ctrl_core;

   import radio_ctrl_pkg::*;

   logic       dsp_clk;
   logic       por_rst;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       run_tx_i, run_rx_i, clk_status_i, serdes_link_i;
   logic       pps_i;
   logic       rd_stb_i;
   rb_addr_t   rd_addr_i;
   set_data_t  rd_data_o;
   logic       rd_ack_o;
   logic       clock_ready_o;
   logic [1:0] clk_en_o, clk_sel_o;
   logic       ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic       adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic       phy_reset_n_o;
   ctrl_byte_t leds_o;
   logic       boot_done_o;
   logic       pps_int_o;

   // Expected state, updated when the stimulus writes a register
   logic [4:0]  exp_clk;
   logic [3:0]  exp_ser, exp_adc;
   logic        exp_phy_n, exp_boot;
   ctrl_byte_t  exp_led_sw, exp_led_src, hw_vec, exp_leds;
   set_data_t   exp_rd, exp_rd_q;
   logic        chk_on;                // Pin checks active
   logic [3:0]  pps_hist;              // pps_i as seen on past edges
   logic [1:0]  boot_hist;
   logic        boot_wr;
   int unsigned check_errs, timeout_errs;

   always #20 dsp_clk = ~dsp_clk;

   radio_ctrl_core dut0 (.*);

   assign hw_vec   = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_i, 1'b0};
   assign boot_wr  = set_stb_i && set_addr_i == set_addr_t'(`SR_MISC + 5) && set_data_i[0]
                     && !boot_done_o;

   // Source bit set picks the hardware bit, clear picks the software bit
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         if (exp_led_src[i]) begin
            exp_leds[i] = hw_vec[i];
         end else begin
            exp_leds[i] = exp_led_sw[i];
         end
      end
   end

   always @(posedge dsp_clk) begin
      exp_rd_q  <= exp_rd;
      pps_hist  <= {pps_hist[2:0], pps_i};
      boot_hist <= {boot_hist[0], boot_wr};
   end

   ////////////////////////////////////////////////////////////////////////
   // Checks

   a_clk: assert property (@(posedge dsp_clk) disable iff (por_rst)
      chk_on |-> {clock_ready_o, clk_en_o, clk_sel_o} == exp_clk)
      else begin
         check_errs++;
         $display("FAILED clock pins: expected 0x%h, got 0x%h", exp_clk,
                  {clock_ready_o, clk_en_o, clk_sel_o});
      end
   a_ser: assert property (@(posedge dsp_clk) disable iff (por_rst)
      chk_on |-> {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} == exp_ser)
      else begin
         check_errs++;
         $display("FAILED serdes pins: expected 0x%h, got 0x%h", exp_ser,
                  {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o});
      end
   a_adc: assert property (@(posedge dsp_clk) disable iff (por_rst)
      chk_on |-> {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} == exp_adc)
      else begin
         check_errs++;
         $display("FAILED adc pins: expected 0x%h, got 0x%h", exp_adc,
                  {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o});
      end
   a_phy: assert property (@(posedge dsp_clk) disable iff (por_rst)
      chk_on |-> phy_reset_n_o == exp_phy_n)
      else begin
         check_errs++;
         $display("FAILED phy_reset_n_o: expected 0x%h, got 0x%h", exp_phy_n, phy_reset_n_o);
      end
   a_leds: assert property (@(posedge dsp_clk) disable iff (por_rst)
      chk_on |-> leds_o == exp_leds)
      else begin
         check_errs++;
         $display("FAILED leds_o: expected 0x%h, got 0x%h", exp_leds, leds_o);
      end
   a_boot_flag: assert property (@(posedge dsp_clk) disable iff (por_rst)
      chk_on |-> boot_done_o == exp_boot)
      else begin
         check_errs++;
         $display("FAILED boot_done_o: expected 0x%h, got 0x%h", exp_boot, boot_done_o);
      end

   // Readback answers one cycle after the strobe, and only then
   a_rd_ack: assert property (@(posedge dsp_clk) disable iff (por_rst)
      rd_stb_i |=> rd_ack_o)
      else begin
         check_errs++;
         $display("FAILED rd_ack_o: expected 0x1, got 0x%h", rd_ack_o);
      end
   a_rd_idle: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !rd_stb_i |=> !rd_ack_o)
      else begin
         check_errs++;
         $display("FAILED rd_ack_o: expected 0x0, got 0x%h", rd_ack_o);
      end
   a_rd_data: assert property (@(posedge dsp_clk) disable iff (por_rst)
      rd_stb_i |=> rd_data_o == exp_rd_q)
      else begin
         check_errs++;
         $display("FAILED rd_data_o: expected 0x%h, got 0x%h", exp_rd_q, rd_data_o);
      end

   a_pps_latency: assert property (@(posedge dsp_clk) disable iff (por_rst)
      pps_int_o |-> pps_hist[2] && !pps_hist[3])
      else begin
         check_errs++;
         $display("PPS interrupt came without a pps_i rising edge three cycles before");
      end
   a_pps_len: assert property (@(posedge dsp_clk) disable iff (por_rst)
      pps_int_o |=> !pps_int_o)
      else begin
         check_errs++;
         $display("FAILED pps_int_o: expected 0x0, got 0x%h", pps_int_o);
      end

   a_boot_done: assert property (@(posedge dsp_clk) disable iff (por_rst)
      boot_wr |=> boot_done_o)
      else begin
         check_errs++;
         $display("FAILED boot_done_o: expected 0x1, got 0x%h", boot_done_o);
      end
   a_boot_regs: assert property (@(posedge dsp_clk) disable iff (por_rst)
      boot_hist[1] |-> {clock_ready_o, clk_en_o, clk_sel_o} == 5'd0 && phy_reset_n_o
         && {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} == 4'd0
         && {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} == 4'd0
         && leds_o == (hw_vec & `LED_SRC_RESET))
      else begin
         check_errs++;
         $display("FAILED boot reset: clk 0x%h ser 0x%h adc 0x%h phy_n 0x%h leds_o 0x%h",
                  {clock_ready_o, clk_en_o, clk_sel_o},
                  {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o},
                  {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}, phy_reset_n_o, leds_o);
      end

   ////////////////////////////////////////////////////////////////////////
   // Stimulus tasks

   task automatic expect_reset_values();
      exp_clk     <= '0;
      exp_ser     <= '0;
      exp_adc     <= '0;
      exp_phy_n   <= 1'b1;
      exp_led_sw  <= '0;
      exp_led_src <= `LED_SRC_RESET;
   endtask

   task automatic write_reg(input set_addr_t addr, input set_data_t data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge dsp_clk);
      set_stb_i  <= 1'b0;
      case (addr)                         // Seen on the pins from the next edge
         set_addr_t'(`SR_MISC + 0): exp_clk     <= data[4:0];
         set_addr_t'(`SR_MISC + 1): exp_ser     <= data[3:0];
         set_addr_t'(`SR_MISC + 2): exp_adc     <= data[3:0];
         set_addr_t'(`SR_MISC + 3): exp_led_sw  <= data[7:0];
         set_addr_t'(`SR_MISC + 4): exp_phy_n   <= ~data[0];
         set_addr_t'(`SR_MISC + 8): exp_led_src <= data[7:0];
         default: ;
      endcase
   endtask

   task automatic read_word(input rb_addr_t addr, input set_data_t expect_val);
      int unsigned waited;
      @(posedge dsp_clk);
      rd_stb_i  <= 1'b1;
      rd_addr_i <= addr;
      exp_rd    <= expect_val;
      @(posedge dsp_clk);
      rd_stb_i  <= 1'b0;
      waited = 0;
      while (!rd_ack_o && waited < 10) begin
         @(posedge dsp_clk);
         waited++;
      end
      if (!rd_ack_o) begin
         timeout_errs++;
         $display("Timeout: no readback acknowledge for word %0d", addr);
      end
   endtask

   task automatic pulse_pps();
      int unsigned waited;
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      waited = 0;
      while (!pps_int_o && waited < 20) begin
         @(posedge dsp_clk);
         waited++;
      end
      if (!pps_int_o) begin
         timeout_errs++;
         $display("Timeout: pps_i pulse gave no PPS interrupt");
      end
      repeat (2) @(posedge dsp_clk);
      pps_i <= 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      set_data_t hi;
      set_data_t lo;
      void'($urandom(39279));
      dsp_clk = 1'b0;
      por_rst = 1'b1;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      {run_tx_i, run_rx_i, clk_status_i, serdes_link_i} = 4'b0000;
      pps_i = 1'b0;
      rd_stb_i = 1'b0;
      rd_addr_i = '0;
      exp_rd = '0;
      exp_boot = 1'b0;
      chk_on = 1'b0;
      pps_hist = '0;
      boot_hist = '0;
      check_errs = 0;
      timeout_errs = 0;
      expect_reset_values();

      repeat (16) @(posedge dsp_clk);
      por_rst <= 1'b0;
      repeat (3) @(posedge dsp_clk);
      chk_on <= 1'b1;
      repeat (4) begin                    // Reset values under changing hardware state
         @(posedge dsp_clk);
         {run_tx_i, run_rx_i, clk_status_i, serdes_link_i} <= 4'($urandom);
      end

      repeat (8) begin
         write_reg(set_addr_t'(`SR_MISC + 0), $urandom);
         write_reg(set_addr_t'(`SR_MISC + 1), $urandom);
         write_reg(set_addr_t'(`SR_MISC + 2), $urandom);
         write_reg(set_addr_t'(`SR_MISC + 4), $urandom);
      end

      repeat (12) begin                   // LED mux
         write_reg(set_addr_t'(`SR_MISC + 3), $urandom);
         write_reg(set_addr_t'(`SR_MISC + 8), $urandom);
         @(posedge dsp_clk);
         {run_tx_i, run_rx_i, clk_status_i, serdes_link_i} <= 4'($urandom);
      end

      read_word(rb_addr_t'(`RB_COMPAT), `COMPAT_NUM);
      read_word(rb_addr_t'(3), '0);
      hi = $urandom;
      lo = $urandom & 32'h0FFF_FFFF;      // Low word stays clear of a carry
      write_reg(set_addr_t'(`SR_TIME64 + 0), hi);
      write_reg(set_addr_t'(`SR_TIME64 + 1), lo);
      write_reg(set_addr_t'(`SR_TIME64 + 2), 32'd0);
      read_word(rb_addr_t'(`RB_TIME_HI), hi);

      // Armed load taken at the next PPS edge
      hi = $urandom;
      lo = $urandom & 32'h0FFF_FFFF;
      write_reg(set_addr_t'(`SR_TIME64 + 0), hi);
      write_reg(set_addr_t'(`SR_TIME64 + 1), lo);
      write_reg(set_addr_t'(`SR_TIME64 + 2), 32'd1);
      pulse_pps();
      read_word(rb_addr_t'(`RB_PPS_HI), hi);
      read_word(rb_addr_t'(`RB_PPS_LO), lo);
      read_word(rb_addr_t'(`RB_TIME_HI), hi);

      // Move every register away from its reset value, then boot
      write_reg(set_addr_t'(`SR_MISC + 0), $urandom | 32'h1);
      write_reg(set_addr_t'(`SR_MISC + 1), $urandom | 32'h1);
      write_reg(set_addr_t'(`SR_MISC + 2), $urandom | 32'h1);
      write_reg(set_addr_t'(`SR_MISC + 3), 32'hFF);
      write_reg(set_addr_t'(`SR_MISC + 4), 32'h1);
      write_reg(set_addr_t'(`SR_MISC + 8), 32'h00);
      @(posedge dsp_clk);
      chk_on     <= 1'b0;
      set_stb_i  <= 1'b1;
      set_addr_i <= set_addr_t'(`SR_MISC + 5);
      set_data_i <= 32'h1;
      @(posedge dsp_clk);
      set_stb_i  <= 1'b0;
      repeat (2) @(posedge dsp_clk);
      expect_reset_values();
      exp_boot <= 1'b1;
      @(posedge dsp_clk);
      chk_on <= 1'b1;
      read_word(rb_addr_t'(`RB_TIME_HI), '0);  // Time restarted from zero
      repeat (4) @(posedge dsp_clk);

      $display("Check errors: %0d, timeouts: %0d", check_errs, timeout_errs);
      if (check_errs == 0 && timeout_errs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* radio_ctrl.f */
+incdir+.
radio_ctrl_pkg.sv
setting_reg.sv
boot_reset_seq.sv
pin_ctrl_regs.sv
vita_timer.sv
readback_mux.sv
radio_ctrl_core.sv
tb_radio_ctrl_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failures
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_radio_ctrl_core -f radio_ctrl.f -o sim_radio_ctrl \
   > build.log 2>&1 &&
./obj_dir/sim_radio_ctrl > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation run error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation reported errors"; exit 1; }
echo "Simulation finished without errors"
exit 0
